//--- sim/tbFemtoCore.sv
// ------------------------------
// Femto core testbench
// ------------------------------
`include "femto_config.svh"

module tbFemtoCore import femtoPkg::*; ();

   logic   clk = 1'b0;
   logic   reset;
   word_t  memAddr;
   word_t  memWdata;
   word_t  memRdata;
   wmask_t memWmask;
   logic   memRstrb;
   logic   memRbusy;
   logic   memWbusy;

   word_t       mem [1024];  // 4 KB behavioral memory
   word_t       expWord [64]; // Expected result area contents
   int          nSlots;
   int          pcw;          // Byte address of the next emitted instruction
   int          errors = 0;
   int          checks = 0;
   int          tests  = 0;
   int          rdCount;
   int          wrCount;
   logic        randomBusy = 1'b0;
   logic [31:0] rngState   = 32'heea7;

   femtoCore u_dut (
      .clk, .reset, .memAddr, .memWdata, .memWmask, .memRdata,
      .memRstrb, .memRbusy, .memWbusy
   );

   always #2 clk = ~clk;

   initial begin
      reset    = 1'b0;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
   end

   function automatic int busyLen();
      if (!randomBusy) return 0;
      rngState = rngState ^ (rngState << 13); // xorshift32
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return int'(rngState % 4);
   endfunction

   // Memory answers strobes and masks with busy stretches drawn per access
   always @(posedge clk) begin : memModel
      int rdLen;
      int wrLen;
      rdLen = busyLen();
      wrLen = busyLen();
      if (!reset) begin
         memRbusy <= 1'b0;
         memWbusy <= 1'b0;
         rdCount  <= 0;
         wrCount  <= 0;
      end else begin
         if (memRstrb) begin
            memRdata <= mem[memAddr[11:2]];
            rdCount  <= rdLen;
            memRbusy <= (rdLen != 0);
         end else if (rdCount > 1) rdCount <= rdCount - 1;
         else begin
            rdCount  <= 0;
            memRbusy <= 1'b0;
         end
         if (|memWmask) begin
            for (int b = 0; b < 4; b++)
               if (memWmask[b]) mem[memAddr[11:2]][8*b +: 8] <= memWdata[8*b +: 8];
            wrCount  <= wrLen;
            memWbusy <= (wrLen != 0);
         end else if (wrCount > 1) wrCount <= wrCount - 1;
         else begin
            wrCount  <= 0;
            memWbusy <= 1'b0;
         end
      end
   end

   task automatic compare(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         $display("[ERROR] %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // Instruction encoders
   function automatic word_t encR(logic [6:0] f7, regIdx_t rs2, regIdx_t rs1, funct3_t f3,
                                  regIdx_t rd, logic [6:0] op);
      return {f7, rs2, rs1, f3, rd, op};
   endfunction
   function automatic word_t encI(logic [11:0] imm, regIdx_t rs1, funct3_t f3, regIdx_t rd,
                                  logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction
   function automatic word_t encS(logic [11:0] imm, regIdx_t rs2, regIdx_t rs1, funct3_t f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
   endfunction
   function automatic word_t encB(logic [12:0] imm, regIdx_t rs2, regIdx_t rs1, funct3_t f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
   endfunction
   function automatic word_t encJ(logic [20:0] imm, regIdx_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
   endfunction

   task automatic emit(input word_t w);
      mem[pcw / 4] = w;
      pcw += 4;
   endtask

   task automatic loadImm(input regIdx_t rd, input word_t v);
      word_t upper;
      upper = (v + 32'h800) >> 12; // Compensate the sign of the ADDI part
      emit({upper[19:0], rd, 7'h37});
      emit(encI(v[11:0], rd, 3'b000, rd, 7'h13));
   endtask

   // Store a register into the next result slot at 0x800
   task automatic result(input regIdx_t rs, input word_t exp);
      emit(encS(12'(nSlots * 4), rs, 5'd30, 3'b010));
      expWord[nSlots] = exp;
      nSlots++;
   endtask

   task automatic checkR(input logic [6:0] f7, input funct3_t f3, input regIdx_t rs1,
                         input regIdx_t rs2, input word_t exp);
      emit(encR(f7, rs2, rs1, f3, 5'd4, 7'h33));
      result(5'd4, exp);
   endtask

   task automatic checkI(input logic [11:0] imm, input funct3_t f3, input regIdx_t rs1,
                         input word_t exp);
      emit(encI(imm, rs1, f3, 5'd4, 7'h13));
      result(5'd4, exp);
   endtask

   // Hold the core in reset, clear memory, emit the base pointers
   task automatic beginProgram();
      @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      for (int i = 0; i < 1024; i++) mem[i] = 32'h5A00_0000 | (i * 32'h0001_0001);
      pcw    = 0;
      nSlots = 0;
      loadImm(5'd30, 32'h800); // Result area
      loadImm(5'd29, 32'hC00); // Load/store scratch word
   endtask

   task automatic runProgram(input string name);
      int   errBefore;
      int   cycles;
      logic seen;
      errBefore = errors;
      tests++;
      emit(encS(12'h7FC, 5'd0, 5'd30, 3'b010)); // Done marker at 0xFFC
      emit(encJ(21'd0, 5'd0));                  // Spin
      repeat (2) begin
         @(negedge clk);
         compare("memWmask", word_t'(memWmask), '0);
      end
      @(posedge clk);
      reset <= 1'b1;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < 100) begin
         @(negedge clk);
         if (memRstrb) seen = 1'b1;
         else compare("memWmask", word_t'(memWmask), '0);
         cycles++;
      end
      if (!seen) begin
         $display("%s: no instruction fetch after reset release", name);
         errors++;
      end else compare("memAddr", memAddr, `FEMTO_RESET_ADDR);
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < 20000) begin
         @(negedge clk);
         seen = (memWmask != '0) && (memAddr == 32'hFFC);
         cycles++;
      end
      if (!seen) begin
         $display("%s: timed out waiting for the done store", name);
         errors++;
      end else begin
         repeat (2) @(posedge clk); // Let the last stores land
         for (int i = 0; i < nSlots; i++)
            compare($sformatf("mem[%h]", 32'h800 + 4 * i), mem[512 + i], expWord[i]);
      end
      $display("%s: %s", name, (errors == errBefore) ? "ok" : "failed");
   endtask

   // Signed-edge operands in x1 to x3
   task automatic arithProgram();
      word_t va;
      word_t vb;
      word_t vc;
      int    p;
      va = 32'h8000_0000;
      vb = 32'h7FFF_FFFF;
      vc = 32'hFFFF_FFFF;
      loadImm(5'd1, va);
      loadImm(5'd2, vb);
      loadImm(5'd3, vc);
      checkR(7'h00, 3'd0, 5'd1, 5'd3, va + vc);
      checkR(7'h20, 3'd0, 5'd1, 5'd2, va - vb);
      checkR(7'h20, 3'd0, 5'd2, 5'd3, vb - vc);
      checkI(12'h001, 3'd0, 5'd2, vb + 1);
      checkI(12'hFFF, 3'd0, 5'd1, va - 1);
      checkR(7'h00, 3'd7, 5'd1, 5'd3, va & vc);
      checkR(7'h00, 3'd6, 5'd1, 5'd2, va | vb);
      checkR(7'h00, 3'd4, 5'd2, 5'd3, vb ^ vc);
      checkI(12'h800, 3'd7, 5'd3, vc & 32'hFFFF_F800);
      checkI(12'h7FF, 3'd6, 5'd1, va | 32'h7FF);
      checkI(12'hF0F, 3'd4, 5'd2, vb ^ 32'hFFFF_FF0F);
      checkR(7'h00, 3'd2, 5'd1, 5'd2, word_t'($signed(va) < $signed(vb)));
      checkR(7'h00, 3'd2, 5'd2, 5'd1, word_t'($signed(vb) < $signed(va)));
      checkR(7'h00, 3'd3, 5'd1, 5'd2, word_t'(va < vb));
      checkR(7'h00, 3'd3, 5'd2, 5'd1, word_t'(vb < va));
      checkI(12'h000, 3'd2, 5'd3, word_t'($signed(vc) < 0));
      checkI(12'hFFF, 3'd3, 5'd2, word_t'(vb < 32'hFFFF_FFFF));
      emit({20'hABCDE, 5'd4, 7'h37}); // LUI
      result(5'd4, 32'hABCD_E000);
      p = pcw;
      emit({20'h80001, 5'd4, 7'h17}); // AUIPC
      result(5'd4, 32'h8000_1000 + p);
      emit(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd0, 7'h33)); // Writes to x0 dropped
      emit(encI(12'h005, 5'd0, 3'd0, 5'd0, 7'h13));
      result(5'd0, '0);
   endtask

   task automatic shiftTest();
      int    amts [6] = '{0, 1, 3, 4, 17, 31};
      word_t sv;
      sv = 32'h8421_F0E1;
      beginProgram();
      loadImm(5'd1, sv);
      foreach (amts[k]) begin
         loadImm(5'd2, amts[k]);
         checkR(7'h00, 3'd1, 5'd1, 5'd2, sv << amts[k]);
         checkR(7'h00, 3'd5, 5'd1, 5'd2, sv >> amts[k]);
         checkR(7'h20, 3'd5, 5'd1, 5'd2, word_t'($signed(sv) >>> amts[k]));
         checkI(12'(amts[k]), 3'd1, 5'd1, sv << amts[k]);
         checkI(12'(amts[k]), 3'd5, 5'd1, sv >> amts[k]);
         checkI(12'h400 | 12'(amts[k]), 3'd5, 5'd1, word_t'($signed(sv) >>> amts[k]));
      end
      runProgram("shifts");
   endtask

   function automatic logic branchRule(funct3_t f3, word_t a, word_t b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         default: return a >= b;
      endcase
   endfunction

   task automatic controlTest();
      funct3_t conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      regIdx_t srcA [3]  = '{5'd1, 5'd2, 5'd1};
      regIdx_t srcB [3]  = '{5'd2, 5'd1, 5'd1};
      word_t   vals [3]  = '{32'h0, 32'h8000_0000, 32'h1}; // By register index
      int      q;
      beginProgram();
      loadImm(5'd1, vals[1]);
      loadImm(5'd2, vals[2]);
      foreach (conds[c]) begin
         for (int k = 0; k < 3; k++) begin
            emit(encI(12'h000, 5'd0, 3'd0, 5'd5, 7'h13));
            emit(encB(13'd8, srcB[k], srcA[k], conds[c])); // Skips the next one
            emit(encI(12'h001, 5'd0, 3'd0, 5'd5, 7'h13));
            result(5'd5, branchRule(conds[c], vals[srcA[k]], vals[srcB[k]]) ? 32'd0 : 32'd1);
         end
      end
      q = pcw;
      emit(encJ(21'd8, 5'd6));
      emit(encI(12'hFFF, 5'd0, 3'd0, 5'd6, 7'h13)); // Clobbers link if not skipped
      result(5'd6, q + 4);
      q = pcw;
      loadImm(5'd8, q + 17); // Odd target whose bit 0 must clear
      emit(encI(12'h000, 5'd8, 3'd0, 5'd9, 7'h67));
      emit(encI(12'hFFF, 5'd0, 3'd0, 5'd9, 7'h13));
      emit({20'h0, 5'd10, 7'h17}); // AUIPC records the landing PC
      result(5'd9, q + 12);
      result(5'd10, q + 16);
      runProgram("control flow");
   endtask

   task automatic memTest();
      word_t e;
      word_t lpat;
      logic [7:0]  b;
      logic [15:0] h;
      lpat = 32'h80FF_7F01;
      beginProgram();
      for (int o = 0; o < 4; o++) begin
         loadImm(5'd1, 32'h1122_3344);
         emit(encS(12'h000, 5'd1, 5'd29, 3'b010));
         loadImm(5'd2, 32'hFFFF_FFC0 + o);
         emit(encS(12'(o), 5'd2, 5'd29, 3'b000)); // SB
         emit(encI(12'h000, 5'd29, 3'b010, 5'd4, 7'h03));
         e = 32'h1122_3344;
         e[8*o +: 8] = 8'hC0 + o;
         result(5'd4, e);
      end
      for (int o = 0; o < 4; o += 2) begin
         loadImm(5'd1, 32'h1122_3344);
         emit(encS(12'h000, 5'd1, 5'd29, 3'b010));
         loadImm(5'd2, 32'hFFFF_BEE0 + o);
         emit(encS(12'(o), 5'd2, 5'd29, 3'b001)); // SH
         emit(encI(12'h000, 5'd29, 3'b010, 5'd4, 7'h03));
         e = 32'h1122_3344;
         e[8*o +: 16] = 16'hBEE0 + o;
         result(5'd4, e);
      end
      loadImm(5'd1, lpat);
      emit(encS(12'h000, 5'd1, 5'd29, 3'b010));
      for (int o = 0; o < 4; o++) begin
         b = lpat[8*o +: 8];
         emit(encI(12'(o), 5'd29, 3'b000, 5'd4, 7'h03)); // LB
         result(5'd4, {{24{b[7]}}, b});
         emit(encI(12'(o), 5'd29, 3'b100, 5'd4, 7'h03)); // LBU
         result(5'd4, {24'h0, b});
      end
      for (int o = 0; o < 4; o += 2) begin
         h = lpat[8*o +: 16];
         emit(encI(12'(o), 5'd29, 3'b001, 5'd4, 7'h03)); // LH
         result(5'd4, {{16{h[15]}}, h});
         emit(encI(12'(o), 5'd29, 3'b101, 5'd4, 7'h03)); // LHU
         result(5'd4, {16'h0, h});
      end
      emit(encI(12'h000, 5'd29, 3'b010, 5'd4, 7'h03));
      result(5'd4, lpat);
      runProgram("loads and stores");
   endtask

   initial begin
      beginProgram();
      runProgram("reset");
      beginProgram();
      arithProgram();
      runProgram("arithmetic");
      shiftTest();
      controlTest();
      memTest();
      randomBusy = 1'b1; // Same program on a stretched bus
      beginProgram();
      arithProgram();
      runProgram("back-pressure");
      randomBusy = 1'b0;
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

//--- src/aluShifter.sv
// ------------------------------
// ALU and iterative shifter
// ------------------------------
`include "femto_config.svh"

module aluShifter import femtoPkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     aluStart,
   input  opClass_e opClass,
   input  funct3_t  funct3,
   input  logic     altFunct,
   input  word_t    rs1,
   input  word_t    rs2,
   input  word_t    immI,
   output word_t    aluOut,
   output word_t    aluPlus,
   output logic     branchTaken,
   output logic     aluBusy
);

   localparam bit TwoLevel = (`FEMTO_TWOLEVEL_SHIFT != 0);

   logic [7:0]  funct3Is; // One-hot funct3
   word_t       aluIn2;
   logic [32:0] aluMinus; // Shared subtractor, bit 32 is the borrow
   logic        lt;
   logic        ltu;
   logic        eq;
   logic        isShift;
   logic        isSub;
   logic        predicate;
   word_t       shiftReg; // Value being shifted
   shamt_t      shamt;    // Remaining count

   assign funct3Is = 8'b0000_0001 << funct3;
   assign aluIn2   = (opClass == OP_ALUREG || opClass == OP_BRANCH) ? rs2 : immI;
   assign aluPlus  = rs1 + aluIn2; // Also the JALR target

   // rs1 - rs2 as rs1 + ~rs2 + 1 over 33 bits
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1} + 33'd1;
   assign ltu      = aluMinus[32];
   assign lt       = (rs1[31] ^ aluIn2[31]) ? rs1[31] : aluMinus[32]; // Signs differ
   assign eq       = (aluMinus[31:0] == '0);

   assign isShift = funct3Is[1] | funct3Is[5];
   assign isSub   = altFunct & (opClass == OP_ALUREG); // ADDI reuses bit 30 as imm

   assign aluOut =
      (funct3Is[0] ? (isSub ? aluMinus[31:0] : aluPlus) : '0) |
      (funct3Is[2] ? {31'b0, lt}                        : '0) |
      (funct3Is[3] ? {31'b0, ltu}                       : '0) |
      (funct3Is[4] ? rs1 ^ aluIn2                       : '0) |
      (funct3Is[6] ? rs1 | aluIn2                       : '0) |
      (funct3Is[7] ? rs1 & aluIn2                       : '0) |
      (isShift     ? shiftReg                           : '0);

   assign predicate =
      funct3Is[0] &  eq  | // BEQ
      funct3Is[1] & ~eq  | // BNE
      funct3Is[4] &  lt  | // BLT
      funct3Is[5] & ~lt  | // BGE
      funct3Is[6] &  ltu | // BLTU
      funct3Is[7] & ~ltu;  // BGEU
   assign branchTaken = (opClass == OP_BRANCH) & predicate;

   assign aluBusy = |shamt;

   // Count: load on start, then steps of four while possible, then ones
   always_ff @(posedge clk) begin
      if (!reset) begin
         shamt <= '0;
      end else if (aluStart && isShift) begin
         shamt <= aluIn2[4:0];
      end else if (TwoLevel && |shamt[4:2]) begin
         shamt <= shamt - shamt_t'(4);
      end else if (|shamt) begin
         shamt <= shamt - shamt_t'(1);
      end
   end

   // Data path follows the same step choice as the count
   always_ff @(posedge clk) begin
      if (aluStart && isShift) begin
         shiftReg <= rs1;
      end else if (TwoLevel && |shamt[4:2]) begin
         shiftReg <= funct3Is[1] ? shiftReg << 4 :
                     {{4{altFunct & shiftReg[31]}}, shiftReg[31:4]};
      end else if (|shamt) begin
         shiftReg <= funct3Is[1] ? shiftReg << 1 :               // SLL
                     {altFunct & shiftReg[31], shiftReg[31:1]};  // SRA or SRL
      end
   end

endmodule

//--- src/execControl.sv
// ------------------------------
// Core controller and PC
// ------------------------------
`include "femto_config.svh"

module execControl import femtoPkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  word_t    memRdata,
   input  logic     memRbusy,
   input  logic     memWbusy,
   output word_t    memAddr,
   output word_t    memWdata,
   output wmask_t   memWmask,
   output logic     memRstrb,
   output word_t    instrReg,
   output logic     fetchDone,
   output logic     aluStart,
   output logic     regWrite,
   output word_t    writeData,
   input  opClass_e opClass,
   input  word_t    immPc,
   input  word_t    immU,
   input  word_t    aluOut,
   input  word_t    aluPlus,
   input  logic     branchTaken,
   input  logic     aluBusy,
   input  addr_t    dataAddr,
   input  word_t    storeData,
   input  wmask_t   storeMask,
   input  word_t    loadData
);

   // SYSTEM opcode, so nothing is written back before the first fetch
   localparam word_t ResetInstr = 32'h0000_0073;

   coreState_e state;
   addr_t      pc;
   addr_t      pcPlus4;
   word_t      pcPlusImm; // Full width so AUIPC keeps the upper bits
   addr_t      pcNext;
   logic       isLoad;
   logic       isStore;
   logic       isAlu;
   logic       isShift;
   logic       inExec;
   logic       inFetch;
   logic       needToWait;
   logic       memIdle;

   assign isLoad  = (opClass == OP_LOAD);
   assign isStore = (opClass == OP_STORE);
   assign isAlu   = (opClass == OP_ALUIMM) || (opClass == OP_ALUREG);
   assign isShift = (instrReg[13:12] == 2'b01); // funct3 001 or 101
   assign inExec  = (state == EXECUTE);
   assign inFetch = (state == FETCH_INSTR) || (state == WAIT_INSTR);

   assign pcPlus4   = pc + addr_t'(4);
   assign pcPlusImm = word_t'(pc) + immPc;
   assign pcNext    = (opClass == OP_JALR) ? (addr_t'(aluPlus) & ~addr_t'(1)) :
                      (opClass == OP_JAL || branchTaken) ? addr_t'(pcPlusImm) :
                      pcPlus4;

   // Load data shows up at the earliest one cycle after the strobe
   assign needToWait = isLoad | (isStore & memWbusy) | (isAlu & isShift);
   assign memIdle    = ~aluBusy & ~memRbusy & ~memWbusy;

   assign fetchDone = (state == WAIT_INSTR) & ~memRbusy;
   assign aluStart  = inExec & isAlu;
   assign regWrite  = (inExec || state == WAIT_ALU_OR_MEM) &&
                      !(opClass == OP_BRANCH || isStore || opClass == OP_SYSTEM);

   // Bus side
   assign memAddr  = word_t'(inFetch ? pc : dataAddr);
   assign memWdata = storeData;
   assign memWmask = (inExec && isStore) ? storeMask : '0;
   assign memRstrb = (state == FETCH_INSTR) | (inExec & isLoad);

   always_comb begin
      case (opClass)
         OP_LOAD:             writeData = loadData;
         OP_ALUIMM, OP_ALUREG: writeData = aluOut;
         OP_LUI:              writeData = immU;
         OP_AUIPC:            writeData = pcPlusImm;
         OP_JAL, OP_JALR:     writeData = word_t'(pcPlus4); // Link
         default:             writeData = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         state    <= WAIT_ALU_OR_MEM; // Let a pending write drain first
         pc       <= addr_t'(`FEMTO_RESET_ADDR);
         instrReg <= ResetInstr;
      end else begin
         case (state)
            FETCH_INSTR: state <= WAIT_INSTR;
            WAIT_INSTR: begin
               if (!memRbusy) begin
                  instrReg <= memRdata;
                  state    <= EXECUTE;
               end
            end
            EXECUTE: begin
               pc    <= pcNext;
               state <= needToWait ? WAIT_ALU_OR_MEM : FETCH_INSTR;
            end
            WAIT_ALU_OR_MEM: begin
               if (memIdle) state <= FETCH_INSTR; // Write-back of this cycle is final
            end
            default: state <= WAIT_ALU_OR_MEM;
         endcase
      end
   end

endmodule

//--- src/femtoCore.sv
// ------------------------------
// Femto RV32I core
// ------------------------------
module femtoCore import femtoPkg::*; (
   input  logic   clk,
   input  logic   reset,
   output word_t  memAddr,
   output word_t  memWdata,
   output wmask_t memWmask,
   input  word_t  memRdata,
   output logic   memRstrb,
   input  logic   memRbusy,
   input  logic   memWbusy
);

   word_t    instrReg;
   logic     fetchDone;
   opClass_e opClass;
   funct3_t  funct3;
   regIdx_t  rdId;
   logic     altFunct;
   word_t    immI;
   word_t    immS;
   word_t    immPc;
   word_t    immU;
   word_t    rs1;
   word_t    rs2;
   word_t    aluOut;
   word_t    aluPlus;
   logic     branchTaken;
   logic     aluBusy;
   addr_t    dataAddr;
   word_t    storeData;
   wmask_t   storeMask;
   word_t    loadData;
   logic     aluStart;
   logic     regWrite;
   word_t    writeData;

   execControl u_ctrl (
      .clk, .reset, .memRdata, .memRbusy, .memWbusy,
      .memAddr, .memWdata, .memWmask, .memRstrb,
      .instrReg, .fetchDone, .aluStart, .regWrite, .writeData,
      .opClass, .immPc, .immU, .aluOut, .aluPlus, .branchTaken, .aluBusy,
      .dataAddr, .storeData, .storeMask, .loadData
   );

   instrDecoder u_dec (
      .instrReg, .opClass, .funct3, .rdId, .altFunct,
      .immI, .immS, .immPc, .immU
   );

   // Source fields come straight off the bus as the instruction lands
   regFile u_regs (
      .clk, .fetchDone, .fetchWord(memRdata), .rs1, .rs2,
      .regWrite, .rdId, .writeData
   );

   aluShifter u_alu (
      .clk, .reset, .aluStart, .opClass, .funct3, .altFunct,
      .rs1, .rs2, .immI, .aluOut, .aluPlus, .branchTaken, .aluBusy
   );

   loadStoreAlign u_lsu (
      .opClass, .funct3, .rs1, .rs2, .immI, .immS, .memRdata,
      .dataAddr, .storeData, .storeMask, .loadData
   );

endmodule

//--- src/femtoPkg.sv
// ------------------------------
// Femto core types
// ------------------------------
package femtoPkg;
`include "femto_config.svh"

   typedef logic [31:0]                   word_t;   // Data or instruction word
   typedef logic [`FEMTO_ADDR_WIDTH-1:0]  addr_t;   // PC or byte address
   typedef logic [4:0]                    regIdx_t; // Register index
   typedef logic [2:0]                    funct3_t; // Function field
   typedef logic [3:0]                    wmask_t;  // Byte write mask
   typedef logic [4:0]                    shamt_t;  // Shift count

   // Opcode classes, one per RV32I major opcode
   typedef enum logic [3:0] {
      OP_LOAD, OP_ALUIMM, OP_AUIPC, OP_STORE, OP_ALUREG, OP_LUI,
      OP_BRANCH, OP_JALR, OP_JAL, OP_SYSTEM, OP_OTHER
   } opClass_e;

   // Controller states
   typedef enum logic [2:0] {
      FETCH_INSTR,
      WAIT_INSTR,
      EXECUTE,
      WAIT_ALU_OR_MEM
   } coreState_e;

endpackage

//--- src/femto_config.svh
// ------------------------------
// Femto core build options
// ------------------------------
`ifndef FEMTO_CONFIG_SVH
`define FEMTO_CONFIG_SVH

// PC value loaded on reset
`define FEMTO_RESET_ADDR 32'h0000_0000

// Internal address bits, upper bus bits read as zero
`define FEMTO_ADDR_WIDTH 24

// 1 adds the shift-by-4 step to the shifter, 0 shifts one bit per cycle
`define FEMTO_TWOLEVEL_SHIFT 1

`endif

//--- src/instrDecoder.sv
// ------------------------------
// Instruction decoder
// ------------------------------
module instrDecoder import femtoPkg::*; (
   input  word_t    instrReg,
   output opClass_e opClass,
   output funct3_t  funct3,
   output regIdx_t  rdId,
   output logic     altFunct,
   output word_t    immI,
   output word_t    immS,
   output word_t    immPc,
   output word_t    immU
);

   word_t immB; // Branch offset
   word_t immJ; // JAL offset

   // Major opcode lives in bits 6:2, bits 1:0 are always 11 in RV32I
   always_comb begin
      case (instrReg[6:2])
         5'b00000: opClass = OP_LOAD;   // rd <- mem[rs1+immI]
         5'b00100: opClass = OP_ALUIMM; // rd <- rs1 op immI
         5'b00101: opClass = OP_AUIPC;  // rd <- PC+immU
         5'b01000: opClass = OP_STORE;  // mem[rs1+immS] <- rs2
         5'b01100: opClass = OP_ALUREG; // rd <- rs1 op rs2
         5'b01101: opClass = OP_LUI;    // rd <- immU
         5'b11000: opClass = OP_BRANCH;
         5'b11001: opClass = OP_JALR;
         5'b11011: opClass = OP_JAL;
         5'b11100: opClass = OP_SYSTEM; // No-op here
         default:  opClass = OP_OTHER;
      endcase
   end

   assign funct3   = instrReg[14:12];
   assign rdId     = instrReg[11:7];
   assign altFunct = instrReg[30]; // SUB and SRA select

   // Sign-extended immediate formats
   assign immI = {{21{instrReg[31]}}, instrReg[30:20]};
   assign immS = {{21{instrReg[31]}}, instrReg[30:25], instrReg[11:7]};
   assign immU = {instrReg[31:12], 12'b0};
   assign immB = {{20{instrReg[31]}}, instrReg[7], instrReg[30:25],
                  instrReg[11:8], 1'b0};
   assign immJ = {{12{instrReg[31]}}, instrReg[19:12], instrReg[20],
                  instrReg[30:21], 1'b0};

   // Offset for the PC adder
   // Bit 3 set only for JAL, bit 4 set for AUIPC, branches have neither
   assign immPc = instrReg[3] ? immJ :
                  instrReg[4] ? immU :
                                immB;

endmodule

//--- src/loadStoreAlign.sv
// ------------------------------
// Load/store alignment
// ------------------------------
module loadStoreAlign import femtoPkg::*; (
   input  opClass_e opClass,
   input  funct3_t  funct3,
   input  word_t    rs1,
   input  word_t    rs2,
   input  word_t    immI,
   input  word_t    immS,
   input  word_t    memRdata,
   output addr_t    dataAddr,
   output word_t    storeData,
   output wmask_t   storeMask,
   output word_t    loadData
);

   logic        isStore;
   logic        byteAccess; // funct3[1:0] 00
   logic        halfAccess; // funct3[1:0] 01
   logic        loadSign;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;

   assign isStore    = (opClass == OP_STORE);
   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   assign dataAddr = addr_t'(rs1) + addr_t'(isStore ? immS : immI);

   // Low byte or halfword copied into the lanes the mask selects
   assign storeData[7:0]   = rs2[7:0];
   assign storeData[15:8]  = dataAddr[0] ? rs2[7:0] : rs2[15:8];
   assign storeData[23:16] = dataAddr[1] ? rs2[7:0] : rs2[23:16];
   assign storeData[31:24] = dataAddr[0] ? rs2[7:0]  :
                             dataAddr[1] ? rs2[15:8] : rs2[31:24];

   always_comb begin
      if (byteAccess) begin
         storeMask = wmask_t'(4'b0001 << dataAddr[1:0]);
      end else if (halfAccess) begin
         storeMask = dataAddr[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111; // Word
      end
   end

   // Pick halfword, then byte within it
   assign loadHalf = dataAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = dataAddr[0] ? loadHalf[15:8] : loadHalf[7:0];

   assign loadSign = ~funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]); // LBU, LHU zero

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  memRdata;

endmodule

//--- src/regFile.sv
// ------------------------------
// Integer register file
// ------------------------------
module regFile import femtoPkg::*; (
   input  logic    clk,
   input  logic    fetchDone,
   input  word_t   fetchWord,
   output word_t   rs1,
   output word_t   rs2,
   input  logic    regWrite,
   input  regIdx_t rdId,
   input  word_t   writeData
);

   word_t   regs [32];
   regIdx_t rs1Id; // Source fields of the word being fetched
   regIdx_t rs2Id;

   assign rs1Id = fetchWord[19:15];
   assign rs2Id = fetchWord[24:20];

   always_ff @(posedge clk) begin
      if (regWrite && rdId != '0) regs[rdId] <= writeData; // x0 never written
   end

   // Operands sampled once per instruction, right when it arrives
   always_ff @(posedge clk) begin
      if (fetchDone) begin
         rs1 <= (rs1Id == '0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
   end

endmodule

//--- vlog.f
+incdir+src
src/femtoPkg.sv
src/instrDecoder.sv
src/regFile.sv
src/aluShifter.sv
src/loadStoreAlign.sv
src/execControl.sv
src/femtoCore.sv
sim/tbFemtoCore.sv
